//--- hw/pmu_pkg.sv
//--------------------------------------------------------------------------
// PMU shared definitions
// AHB-lite request and response structs, the register write bundle,
// the decoded configuration and the register map of the monitor
//--------------------------------------------------------------------------

package pmu_pkg;

    // Register and bus widths
    localparam int REG_WIDTH  = 32;
    localparam int ADDR_WIDTH = 32;

    //----------------------------------------------------------------------
    // Register map
    //----------------------------------------------------------------------

    // Configuration word sits first, counters follow, status comes last
    localparam logic [7:0] CFG_IDX = 8'd0;

    // Bit positions inside the configuration word
    localparam int CFG_EN_BIT     = 0;
    localparam int CFG_CLR_BIT    = 1;
    localparam int CFG_IRQ_EN_BIT = 2;

    // Response code returned on every transfer
    localparam logic [1:0] RESP_OKAY = 2'b00;

    //----------------------------------------------------------------------
    // Types
    //----------------------------------------------------------------------

    typedef logic [REG_WIDTH-1:0] reg_word_t;

    // AHB transfer type as driven on htrans
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Master to slave
    typedef struct packed {
        logic                  sel;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  write;
        htrans_e               trans;
        reg_word_t             wdata;
    } ahb_req_t;

    // Slave to master
    typedef struct packed {
        logic       ready;
        logic [1:0] resp;
        reg_word_t  rdata;
    } ahb_rsp_t;

    // Data-phase write towards the register owners
    typedef struct packed {
        logic       valid;
        logic [7:0] index;
        reg_word_t  data;
    } reg_wr_t;

    // Decoded configuration
    typedef struct packed {
        logic en;
        logic clr;
        logic irq_en;
    } cfg_t;

endpackage

//--- hw/pmu_ahb_slave.sv
//--------------------------------------------------------------------------
// PMU AHB-lite slave
// Captures the address phase and turns the following data phase into a
// register write or a combined read from the register owners
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module pmu_ahb_slave #(
    parameter int N_COUNTERS = 8
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  pmu_pkg::ahb_req_t  ahb_req_i,
    input  pmu_pkg::reg_word_t cfg_rdata_i,
    input  pmu_pkg::reg_word_t cnt_rdata_i,
    output pmu_pkg::ahb_rsp_t  ahb_rsp_o,
    output pmu_pkg::reg_wr_t   reg_wr_o,
    output logic [7:0]         rd_index_o
);
    import pmu_pkg::*;

    // Highest word index backed by a register (the status word)
    localparam int unsigned LAST_IDX = N_COUNTERS + 1;
    // Index given to addresses outside the 256 word window
    // Never matches a register since N_COUNTERS is at most 32
    localparam logic [7:0] BAD_IDX = 8'hFF;

    logic       accept;
    logic [7:0] ap_index;
    logic       dp_sel_q;
    logic       dp_write_q;
    logic [7:0] dp_index_q;
    logic       dp_read;

    //----------------------------------------------------------------------
    // Address phase
    //----------------------------------------------------------------------

    // Only NONSEQ and SEQ carry a transfer
    // IDLE and BUSY are dropped without a data phase
    assign accept = ahb_req_i.sel &&
                    ((ahb_req_i.trans == NONSEQ) || (ahb_req_i.trans == SEQ));

    // Word index from the byte address
    // upper address bits set means no register is hit
    assign ap_index = (|ahb_req_i.addr[ADDR_WIDTH-1:10]) ? BAD_IDX
                                                        : ahb_req_i.addr[9:2];

    // hready is always high so every cycle is a valid address phase
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            dp_sel_q   <= 1'b0;
            dp_write_q <= 1'b0;
            dp_index_q <= '0;
        end else begin
            dp_sel_q   <= accept;
            dp_write_q <= accept && ahb_req_i.write;
            // Keep the old index while idle
            if (accept) begin
                dp_index_q <= ap_index;
            end
        end
    end

    //----------------------------------------------------------------------
    // Data phase
    //----------------------------------------------------------------------

    assign dp_read = dp_sel_q && !dp_write_q;

    // Write strobe with hwdata from the current cycle
    // Owners update on the next edge
    always_comb begin
        reg_wr_o.valid = dp_sel_q && dp_write_q;
        reg_wr_o.index = dp_index_q;
        reg_wr_o.data  = ahb_req_i.wdata;
    end

    // Both owners return zero for indices they do not hold
    assign rd_index_o = dp_index_q;

    // No wait states and no error responses
    always_comb begin
        ahb_rsp_o.ready = 1'b1;
        ahb_rsp_o.resp  = RESP_OKAY;
        ahb_rsp_o.rdata = dp_read ? (cfg_rdata_i | cnt_rdata_i) : '0;
    end

    //----------------------------------------------------------------------
    // Assertions
    //----------------------------------------------------------------------

    // A write strobe only follows an accepted write address phase
    property p_wr_after_accept;
        @(posedge clk_i) disable iff (!rstn_i)
        reg_wr_o.valid |-> $past(accept && ahb_req_i.write);
    endproperty

    a_wr_after_accept: assert property (p_wr_after_accept)
        else $error("reg_wr_o.valid without an accepted write phase");

    // Reads past the status word get zero from both owners
    property p_oor_read_zero;
        @(posedge clk_i) disable iff (!rstn_i)
        (dp_read && (dp_index_q > LAST_IDX)) |-> (ahb_rsp_o.rdata == '0);
    endproperty

    a_oor_read_zero: assert property (p_oor_read_zero)
        else $error("nonzero rdata for out-of-range index %0d", dp_index_q);

endmodule

//--- hw/pmu_cfg_regs.sv
//--------------------------------------------------------------------------
// PMU configuration and status registers
// Holds enable, clear pulse and interrupt enable, collects counter wraps
// in a write-one-to-clear status word and raises the overflow interrupt
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module pmu_cfg_regs #(
    parameter int N_COUNTERS = 8
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  pmu_pkg::reg_wr_t      reg_wr_i,
    input  logic [7:0]            rd_index_i,
    input  logic [N_COUNTERS-1:0] wrap_i,
    output pmu_pkg::cfg_t         cfg_o,
    output pmu_pkg::reg_word_t    rdata_o,
    output logic                  intr_overflow_o
);
    import pmu_pkg::*;

    // Status word follows the last counter
    localparam logic [7:0] STATUS_IDX = 8'(N_COUNTERS + 1);

    cfg_t                  cfg_q;
    logic [N_COUNTERS-1:0] status_q;
    logic [N_COUNTERS-1:0] status_clr;
    logic                  cfg_wr;
    logic                  status_wr;

    // Write decode for the two words owned here
    assign cfg_wr    = reg_wr_i.valid && (reg_wr_i.index == CFG_IDX);
    assign status_wr = reg_wr_i.valid && (reg_wr_i.index == STATUS_IDX);

    // Bits written as one are cleared
    assign status_clr = status_wr ? reg_wr_i.data[N_COUNTERS-1:0] : '0;

    //----------------------------------------------------------------------
    // Configuration word
    //----------------------------------------------------------------------

    // clr is a one cycle pulse towards the counters
    // A clear request during the pulse folds into it
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cfg_q <= '0;
        end else if (cfg_wr) begin
            cfg_q.en     <= reg_wr_i.data[CFG_EN_BIT];
            cfg_q.clr    <= reg_wr_i.data[CFG_CLR_BIT] && !cfg_q.clr;
            cfg_q.irq_en <= reg_wr_i.data[CFG_IRQ_EN_BIT];
        end else begin
            cfg_q.clr <= 1'b0;
        end
    end

    assign cfg_o = cfg_q;

    //----------------------------------------------------------------------
    // Overflow status and interrupt
    //----------------------------------------------------------------------

    // Wrap is ORed in after the clear so a wrap in the same cycle wins
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            status_q        <= '0;
            intr_overflow_o <= 1'b0;
        end else begin
            status_q        <= (status_q & ~status_clr) | wrap_i;
            // Level interrupt, one cycle behind the status word
            intr_overflow_o <= cfg_q.irq_en && (|status_q);
        end
    end

    // Read mux, clear bit always reads back as zero
    always_comb begin
        rdata_o = '0;
        if (rd_index_i == CFG_IDX) begin
            rdata_o[CFG_EN_BIT]     = cfg_q.en;
            rdata_o[CFG_IRQ_EN_BIT] = cfg_q.irq_en;
        end else if (rd_index_i == STATUS_IDX) begin
            rdata_o[N_COUNTERS-1:0] = status_q;
        end
    end

    //----------------------------------------------------------------------
    // Assertions
    //----------------------------------------------------------------------

    a_clr_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cfg_q.clr |=> !cfg_q.clr)
        else $error("cfg clear bit high for two cycles");

    a_irq_masked: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !cfg_q.irq_en |=> !intr_overflow_o)
        else $error("intr_overflow_o high with irq_en low");

endmodule

//--- hw/pmu_counters.sv
//--------------------------------------------------------------------------
// PMU event counters
// One 32 bit counter per event line with software write, global clear
// and increment, plus a wrap pulse when a counter rolls over
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module pmu_counters #(
    parameter int N_COUNTERS = 8
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [N_COUNTERS-1:0] events_i,
    input  pmu_pkg::cfg_t         cfg_i,
    input  pmu_pkg::reg_wr_t      reg_wr_i,
    input  logic [7:0]            rd_index_i,
    output pmu_pkg::reg_word_t    rdata_o,
    output logic [N_COUNTERS-1:0] wrap_o
);
    import pmu_pkg::*;

    reg_word_t             cnt_q [N_COUNTERS];
    logic [N_COUNTERS-1:0] cnt_wr;
    logic [N_COUNTERS-1:0] cnt_inc;

    for (genvar i = 0; i < N_COUNTERS; i++) begin : g_cnt
        // Counter i lives right after the configuration word
        localparam logic [7:0] IDX = 8'(i + 1);

        assign cnt_wr[i]  = reg_wr_i.valid && (reg_wr_i.index == IDX);
        assign cnt_inc[i] = cfg_i.en && events_i[i];

        // Wrap only when the increment actually takes effect
        assign wrap_o[i] = cnt_inc[i] && !cnt_wr[i] && !cfg_i.clr && (&cnt_q[i]);

        // Priority is write, then clear, then increment
        always_ff @(posedge clk_i) begin
            if (!rstn_i) begin
                cnt_q[i] <= '0;
            end else if (cnt_wr[i]) begin
                cnt_q[i] <= reg_wr_i.data;
            end else if (cfg_i.clr) begin
                cnt_q[i] <= '0;
            end else if (cnt_inc[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end

        // Counting stopped means the value only moves by software
        a_hold_disabled: assert property (@(posedge clk_i) disable iff (!rstn_i)
            (!cfg_i.en && !cnt_wr[i] && !cfg_i.clr) |=> $stable(cnt_q[i]))
            else $error("counter %0d changed while disabled", i);

        // A reported wrap leaves the counter at zero
        a_wrap_to_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
            wrap_o[i] |=> (cnt_q[i] == '0))
            else $error("counter %0d nonzero after wrap", i);
    end

    //----------------------------------------------------------------------
    // Read mux
    //----------------------------------------------------------------------

    // Zero for any index outside the counter range
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (rd_index_i == 8'(i + 1)) begin
                rdata_o = cnt_q[i];
            end
        end
    end

endmodule

//--- hw/pmu_ahb_top.sv
//--------------------------------------------------------------------------
// PMU top level
// AHB-lite slave in front of the configuration, status and counter bank
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module pmu_ahb_top #(
    parameter int N_COUNTERS = 8
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  pmu_pkg::ahb_req_t     ahb_req_i,
    input  logic [N_COUNTERS-1:0] events_i,
    output pmu_pkg::ahb_rsp_t     ahb_rsp_o,
    output logic                  intr_overflow_o
);
    import pmu_pkg::*;

    // Data-phase write and read index from the slave
    reg_wr_t               reg_wr;
    logic [7:0]            rd_index;
    // Read data of each owner, zero when not addressed
    reg_word_t             cfg_rdata;
    reg_word_t             cnt_rdata;
    // Control towards the counters and wraps back
    cfg_t                  cfg;
    logic [N_COUNTERS-1:0] wrap;

    pmu_ahb_slave #(
        .N_COUNTERS (N_COUNTERS)
    ) u_slave (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .ahb_req_i   (ahb_req_i),
        .cfg_rdata_i (cfg_rdata),
        .cnt_rdata_i (cnt_rdata),
        .ahb_rsp_o   (ahb_rsp_o),
        .reg_wr_o    (reg_wr),
        .rd_index_o  (rd_index)
    );

    pmu_cfg_regs #(
        .N_COUNTERS (N_COUNTERS)
    ) u_cfg_regs (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_wr_i        (reg_wr),
        .rd_index_i      (rd_index),
        .wrap_i          (wrap),
        .cfg_o           (cfg),
        .rdata_o         (cfg_rdata),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_counters #(
        .N_COUNTERS (N_COUNTERS)
    ) u_counters (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .events_i   (events_i),
        .cfg_i      (cfg),
        .reg_wr_i   (reg_wr),
        .rd_index_i (rd_index),
        .rdata_o    (cnt_rdata),
        .wrap_o     (wrap)
    );

endmodule

//--- test/pmu_tb_clk_gen.sv
//--------------------------------------------------------------------------
// PMU testbench clock and reset
// Free running clock and an active low reset held for a few cycles
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module pmu_tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release just after an edge so the DUT sees a clean synchronous reset
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rstn_o = 1'b1;
    end

endmodule

//--- test/pmu_tb.sv
//--------------------------------------------------------------------------
// PMU testbench
// Runs a table of AHB writes, reads, event bursts and interrupt waits
// against the monitor and compares every read with the expected value
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module pmu_tb;
    import pmu_pkg::*;

    localparam int          N_CNT          = 4;
    localparam logic [7:0]  STATUS_IDX     = 8'(N_CNT + 1);
    localparam int          TIMEOUT_CYCLES = 50;
    localparam int          DRIVE_DLY      = 2;
    localparam logic [31:0] RAND_SEED      = 32'hed5ba447;

    typedef enum logic [2:0] {
        S_WRITE,
        S_READ,
        S_EVENTS,
        S_IDLE,
        S_IRQ,
        S_IRQ_NOW
    } step_kind_e;

    // One row of the stimulus table
    typedef struct packed {
        step_kind_e       kind;
        logic [7:0]       index;
        reg_word_t        data;
        logic [N_CNT-1:0] mask;
        logic [7:0]       cycles;
        reg_word_t        expected;
    } step_t;

    logic             clk;
    logic             rstn;
    ahb_req_t         ahb_req;
    ahb_rsp_t         ahb_rsp;
    logic [N_CNT-1:0] events;
    logic             intr_overflow;

    step_t     steps[$];
    // Counter values expected from the rows queued so far
    reg_word_t cnt_exp [N_CNT];

    pmu_tb_clk_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (8)
    ) u_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    pmu_ahb_top #(
        .N_COUNTERS (N_CNT)
    ) dut (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .ahb_req_i       (ahb_req),
        .events_i        (events),
        .ahb_rsp_o       (ahb_rsp),
        .intr_overflow_o (intr_overflow)
    );

    //----------------------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------------------

    task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
        if (act !== exp) begin
            $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_irq(input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: intr_overflow_o expected 0x%0h, got 0x%0h", exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch on intr_overflow_o");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "%s", what);
    endtask

    //----------------------------------------------------------------------
    // Bus and event drivers
    //----------------------------------------------------------------------

    // Inputs change a short delay after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Waits in the data phase until the slave is ready, sampling at negedge
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (ahb_rsp.ready !== 1'b1) begin
            if (n == TIMEOUT_CYCLES) begin
                stop_on_timeout("hready");
            end
            n++;
            @(negedge clk);
        end
        check_word("ahb_rsp_o.resp", 32'(RESP_OKAY), 32'(ahb_rsp.resp));
    endtask

    task automatic address_phase(input logic [7:0] index, input logic write);
        ahb_req.sel   = 1'b1;
        ahb_req.addr  = 32'(index) << 2;
        ahb_req.write = write;
        ahb_req.trans = NONSEQ;
        next_cycle();
        // Data phase, bus goes idle behind it
        ahb_req.sel   = 1'b0;
        ahb_req.addr  = '0;
        ahb_req.write = 1'b0;
        ahb_req.trans = IDLE;
    endtask

    task automatic ahb_write(input logic [7:0] index, input reg_word_t data);
        address_phase(index, 1'b1);
        ahb_req.wdata = data;
        wait_ready();
        next_cycle();
        ahb_req.wdata = '0;
    endtask

    task automatic ahb_read(input logic [7:0] index, output reg_word_t data);
        address_phase(index, 1'b0);
        wait_ready();
        data = ahb_rsp.rdata;
        next_cycle();
    endtask

    // Holds the mask for a number of clock edges, then drops it
    task automatic drive_events(input logic [N_CNT-1:0] mask, input logic [7:0] cycles);
        events = mask;
        repeat (cycles) next_cycle();
        events = '0;
    endtask

    // Interrupt has to reach the level before the timeout
    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (intr_overflow !== level) begin
            if (n == TIMEOUT_CYCLES) begin
                stop_on_timeout("intr_overflow_o");
            end
            n++;
            @(negedge clk);
        end
        next_cycle();
    endtask

    // Interrupt must already sit at the level on the next falling edge
    task automatic sample_irq(input logic level);
        @(negedge clk);
        check_irq(level, intr_overflow);
        next_cycle();
    endtask

    //----------------------------------------------------------------------
    // Stimulus table
    //----------------------------------------------------------------------

    function automatic void add_step(input step_kind_e kind, input logic [7:0] index,
                                     input reg_word_t data, input logic [N_CNT-1:0] mask,
                                     input int cycles, input reg_word_t expected);
        step_t s;
        s          = '0;
        s.kind     = kind;
        s.index    = index;
        s.data     = data;
        s.mask     = mask;
        s.cycles   = 8'(cycles);
        s.expected = expected;
        steps.push_back(s);
    endfunction

    // Event burst with en set, every selected counter gains k
    function automatic void count_events(input logic [N_CNT-1:0] mask, input int k);
        add_step(S_EVENTS, 8'd0, '0, mask, k, '0);
        for (int i = 0; i < N_CNT; i++) begin
            if (mask[i]) begin
                cnt_exp[i] = cnt_exp[i] + reg_word_t'(k);
            end
        end
    endfunction

    function automatic void build_table();
        // Reset state of every word and the interrupt
        for (int i = 0; i <= STATUS_IDX; i++) begin
            add_step(S_READ, 8'(i), '0, '0, 0, '0);
        end
        add_step(S_IRQ_NOW, 8'd0, '0, '0, 0, 32'd0);

        // Clear bit reads back as zero, irq_en sticks
        add_step(S_WRITE, CFG_IDX, 32'h6, '0, 0, '0);
        add_step(S_READ, CFG_IDX, '0, '0, 0, 32'h4);

        // Kept below the top bit so counting never wraps
        for (int i = 0; i < N_CNT; i++) begin
            cnt_exp[i] = $urandom & 32'h7fff_ffff;
            add_step(S_WRITE, 8'(i + 1), cnt_exp[i], '0, 0, '0);
        end
        // Events with counting disabled leave the counters alone
        add_step(S_EVENTS, 8'd0, '0, '1, 5, '0);
        for (int i = 0; i < N_CNT; i++) begin
            add_step(S_READ, 8'(i + 1), '0, '0, 0, cnt_exp[i]);
        end
        add_step(S_READ, STATUS_IDX + 8'd1, '0, '0, 0, '0);
        add_step(S_READ, 8'd200, '0, '0, 0, '0);

        //------------------------------------------------------------------
        // Counting with en set
        //------------------------------------------------------------------
        add_step(S_WRITE, CFG_IDX, 32'h1, '0, 0, '0);
        count_events(4'b0101, 7);
        add_step(S_IDLE, 8'd0, '0, '0, 2, '0);
        count_events(4'b1010, 3);
        for (int i = 0; i < N_CNT; i++) begin
            add_step(S_READ, 8'(i + 1), '0, '0, 0, cnt_exp[i]);
        end
        add_step(S_READ, CFG_IDX, '0, '0, 0, 32'h1);

        // Clear zeroes all counters and en stays
        add_step(S_WRITE, CFG_IDX, 32'h3, '0, 0, '0);
        for (int i = 0; i < N_CNT; i++) begin
            add_step(S_READ, 8'(i + 1), '0, '0, 0, '0);
        end
        add_step(S_READ, CFG_IDX, '0, '0, 0, 32'h1);

        //------------------------------------------------------------------
        // Overflow, interrupt and its clear
        //------------------------------------------------------------------
        add_step(S_WRITE, CFG_IDX, 32'h5, '0, 0, '0);
        add_step(S_WRITE, 8'd1, 32'hffff_ffff, '0, 0, '0);
        add_step(S_READ, 8'd1, '0, '0, 0, 32'hffff_ffff);
        add_step(S_EVENTS, 8'd0, '0, 4'b0001, 1, '0);
        add_step(S_READ, 8'd1, '0, '0, 0, 32'h0);
        add_step(S_READ, STATUS_IDX, '0, '0, 0, 32'h1);
        add_step(S_IRQ, 8'd0, '0, '0, 0, 32'd1);

        // Write one to clear status bit 0
        add_step(S_WRITE, STATUS_IDX, 32'h1, '0, 0, '0);
        add_step(S_IRQ, 8'd0, '0, '0, 0, 32'd0);
        add_step(S_READ, STATUS_IDX, '0, '0, 0, 32'h0);

        // Wrap again, then mask the interrupt with the status still set
        add_step(S_WRITE, 8'd1, 32'hffff_ffff, '0, 0, '0);
        add_step(S_EVENTS, 8'd0, '0, 4'b0001, 1, '0);
        add_step(S_IRQ, 8'd0, '0, '0, 0, 32'd1);
        add_step(S_WRITE, CFG_IDX, 32'h1, '0, 0, '0);
        add_step(S_IRQ, 8'd0, '0, '0, 0, 32'd0);
        add_step(S_IDLE, 8'd0, '0, '0, 5, '0);
        add_step(S_IRQ_NOW, 8'd0, '0, '0, 0, 32'd0);
        add_step(S_READ, STATUS_IDX, '0, '0, 0, 32'h1);
    endfunction

    task automatic apply_step(input step_t s);
        reg_word_t rdata;
        case (s.kind)
            S_WRITE: ahb_write(s.index, s.data);
            S_READ: begin
                ahb_read(s.index, rdata);
                check_word($sformatf("ahb_rsp_o.rdata[word %0d]", s.index), s.expected, rdata);
            end
            S_EVENTS:  drive_events(s.mask, s.cycles);
            S_IDLE:    repeat (s.cycles) next_cycle();
            S_IRQ:     wait_irq(s.expected[0]);
            S_IRQ_NOW: sample_irq(s.expected[0]);
            default:   stop_with_error("Unknown step kind in the stimulus table");
        endcase
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------

    initial begin
        int n;
        void'($urandom(RAND_SEED));
        ahb_req = '0;
        events  = '0;
        build_table();

        n = 0;
        while (rstn !== 1'b1) begin
            if (n == TIMEOUT_CYCLES) begin
                stop_on_timeout("reset release");
            end
            n++;
            @(posedge clk);
        end
        next_cycle();

        foreach (steps[i]) begin
            apply_step(steps[i]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sources.f
hw/pmu_pkg.sv
hw/pmu_ahb_slave.sv
hw/pmu_cfg_regs.sv
hw/pmu_counters.sv
hw/pmu_ahb_top.sv
test/pmu_tb_clk_gen.sv
test/pmu_tb.sv

//--- Bender.yml
package:
  name: pmu_ahb

sources:
  - files:
      - hw/pmu_pkg.sv
      - hw/pmu_ahb_slave.sv
      - hw/pmu_cfg_regs.sv
      - hw/pmu_counters.sv
      - hw/pmu_ahb_top.sv

  - target: test
    files:
      - test/pmu_tb_clk_gen.sv
      - test/pmu_tb.sv
